/* design/poker_pkg.sv */
package poker_pkg;

    // chip amounts for balances, pot and bets.
    typedef logic [6:0] chips_t;

    // 0 is player 1, 1 is player 2.
    typedef logic player_t;

    typedef enum logic [1:0] {
        preflop = 2'd0,
        flop    = 2'd1,
        turn    = 2'd2,
        river   = 2'd3
    } round_e;

    typedef enum logic [1:0] {
        mode_playing = 2'd0,
        mode_cashout = 2'd1,
        mode_freeze  = 2'd2
    } mode_e;

    localparam chips_t START_BALANCE = 7'd49;
    localparam chips_t RAISE_STEP    = 7'd5;   // fixed raise per press.

endpackage

/* design/display_pkg.sv */
package display_pkg;

    typedef logic [3:0] digit_t;

    // segments g..a, active low.
    typedef logic [6:0] seg_t;

    function automatic seg_t seg_encode(digit_t d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;   // blank.
        endcase
    endfunction

endpackage

/* design/player_action_if.sv */
interface player_action_if;

    logic fold;      // one-cycle strobes.
    logic call;
    logic raise;
    logic cashout;   // debounced levels.
    logic freeze;

    modport conditioner (
        output fold, call, raise, cashout, freeze
    );

    modport mode (
        input cashout, freeze
    );

    modport bet (
        input fold, call, raise
    );

endinterface

/* design/button_conditioner.sv */
module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 1000000
) (
    input  logic clk,
    input  logic reset_d,
    input  logic btn_fold,
    input  logic btn_call,
    input  logic btn_raise,
    input  logic sw_cashout,
    input  logic sw_freeze,
    player_action_if.conditioner act
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [4:0] raw;
    logic [4:0] level;
    logic [2:0] level_q;
    logic [2:0] strobe;

    // buttons low, switches high.
    assign raw = {sw_freeze, sw_cashout, btn_raise, btn_call, btn_fold};

    for (genvar i = 0; i < 5; i++) begin : g_debounce
        logic             sync;
        logic             stable;
        logic [CNT_W-1:0] cnt;

        always_ff @(posedge clk or posedge reset_d) begin
            if (reset_d) begin
                sync   <= 1'b0;
                stable <= 1'b0;
                cnt    <= '0;
            end else begin
                sync <= raw[i];
                if (sync == stable) begin
                    cnt <= '0;   // bounce restarts the count.
                end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    stable <= sync;
                    cnt    <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end

        assign level[i] = stable;
    end

    // rising edge of each button level.
    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            level_q <= '0;
            strobe  <= '0;
        end else begin
            level_q <= level[2:0];
            strobe  <= level[2:0] & ~level_q;
        end
    end

    assign act.fold    = strobe[0];
    assign act.call    = strobe[1];
    assign act.raise   = strobe[2];
    assign act.cashout = level[3];
    assign act.freeze  = level[4];

endmodule

/* design/game_mode_fsm.sv */
module game_mode_fsm
    import poker_pkg::*;
(
    input  logic   clk,
    input  logic   reset_d,
    player_action_if.mode act,
    input  round_e round,
    output logic   betting_enable,
    output logic   new_game
);

    mode_e mode;
    mode_e mode_n;
    mode_e saved;     // mode to return to after freeze.
    mode_e saved_n;
    logic  leave_cashout;

    always_comb begin
        mode_n        = mode;
        saved_n       = saved;
        leave_cashout = 1'b0;
        case (mode)
            mode_playing: begin
                if (act.freeze) begin
                    mode_n  = mode_freeze;
                    saved_n = mode_playing;
                end else if (act.cashout && round == preflop) begin
                    mode_n = mode_cashout;   // only between hands.
                end
            end
            mode_cashout: begin
                if (act.freeze) begin
                    mode_n  = mode_freeze;
                    saved_n = mode_cashout;
                end else if (!act.cashout) begin
                    mode_n        = mode_playing;
                    leave_cashout = 1'b1;
                end
            end
            mode_freeze: begin
                if (!act.freeze)
                    mode_n = saved;
            end
            default: mode_n = mode_playing;
        endcase
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            mode     <= mode_playing;
            saved    <= mode_playing;
            new_game <= 1'b0;
        end else begin
            mode     <= mode_n;
            saved    <= saved_n;
            new_game <= leave_cashout;   // fresh balances on return.
        end
    end

    assign betting_enable = (mode == mode_playing);

endmodule

/* design/betting_engine.sv */
module betting_engine
    import poker_pkg::*;
(
    input  logic    clk,
    input  logic    reset_d,
    player_action_if.bet act,
    input  logic    betting_enable,
    input  logic    new_game,
    input  logic    win,
    input  logic    tie,
    output round_e  round,
    output player_t cur_player,
    output chips_t  pot,
    output chips_t  p1_balance,
    output chips_t  p2_balance
);

    chips_t  cur_bet;
    chips_t  p1_bet;        // amounts put in this round.
    chips_t  p2_bet;
    player_t first_player;

    round_e  round_n;
    player_t player_n;
    chips_t  pot_n;
    chips_t  p1_bal_n;
    chips_t  p2_bal_n;
    chips_t  cur_bet_n;
    chips_t  p1_bet_n;
    chips_t  p2_bet_n;
    player_t first_n;

    chips_t  actor_bet;
    chips_t  owed;
    chips_t  pot_in;
    chips_t  half_pot;
    chips_t  raise_cost;
    chips_t  raise_bet;
    logic    closing;

    assign actor_bet  = cur_player ? p2_bet : p1_bet;
    assign owed       = cur_bet - actor_bet;   // zero on a check.
    assign pot_in     = pot + owed;
    assign half_pot   = pot_in >> 1;           // tie split rounds down.
    assign raise_cost = owed + RAISE_STEP;
    assign raise_bet  = cur_bet + RAISE_STEP;

    // a call, or a check by the second actor, ends the round.
    assign closing = (cur_bet != '0) || (cur_player != first_player);

    always_comb begin
        round_n   = round;
        player_n  = cur_player;
        pot_n     = pot;
        p1_bal_n  = p1_balance;
        p2_bal_n  = p2_balance;
        cur_bet_n = cur_bet;
        p1_bet_n  = p1_bet;
        p2_bet_n  = p2_bet;
        first_n   = first_player;
        if (betting_enable) begin
            if (act.fold) begin
                if (cur_player)
                    p1_bal_n = p1_balance + pot;
                else
                    p2_bal_n = p2_balance + pot;
                pot_n     = '0;
                cur_bet_n = '0;
                p1_bet_n  = '0;
                p2_bet_n  = '0;
                round_n   = preflop;
                first_n   = ~first_player;
                player_n  = ~first_player;
            end else if (act.call) begin
                if (closing) begin
                    if (cur_player)
                        p2_bal_n = p2_balance - owed;
                    else
                        p1_bal_n = p1_balance - owed;
                    pot_n     = pot_in;
                    cur_bet_n = '0;
                    p1_bet_n  = '0;
                    p2_bet_n  = '0;
                    if (round == river) begin
                        // showdown.
                        if (tie) begin
                            p1_bal_n = p1_bal_n + half_pot;
                            p2_bal_n = p2_bal_n + half_pot;
                        end else if (win) begin
                            p1_bal_n = p1_bal_n + pot_in;
                        end else begin
                            p2_bal_n = p2_bal_n + pot_in;
                        end
                        pot_n    = '0;
                        round_n  = preflop;
                        first_n  = ~first_player;
                        player_n = ~first_player;
                    end else begin
                        round_n  = round_e'(round + 2'd1);
                        player_n = first_player;
                    end
                end else begin
                    player_n = ~cur_player;
                end
            end else if (act.raise) begin
                if (cur_player) begin
                    p2_bal_n = p2_balance - raise_cost;
                    p2_bet_n = raise_bet;
                end else begin
                    p1_bal_n = p1_balance - raise_cost;
                    p1_bet_n = raise_bet;
                end
                pot_n     = pot + raise_cost;
                cur_bet_n = raise_bet;
                player_n  = ~cur_player;
            end
        end
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            round        <= preflop;
            cur_player   <= 1'b0;
            pot          <= '0;
            p1_balance   <= START_BALANCE;
            p2_balance   <= START_BALANCE;
            cur_bet      <= '0;
            p1_bet       <= '0;
            p2_bet       <= '0;
            first_player <= 1'b0;
        end else if (new_game) begin
            round        <= preflop;
            cur_player   <= 1'b0;
            pot          <= '0;
            p1_balance   <= START_BALANCE;
            p2_balance   <= START_BALANCE;
            cur_bet      <= '0;
            p1_bet       <= '0;
            p2_bet       <= '0;
            first_player <= 1'b0;
        end else begin
            round        <= round_n;
            cur_player   <= player_n;
            pot          <= pot_n;
            p1_balance   <= p1_bal_n;
            p2_balance   <= p2_bal_n;
            cur_bet      <= cur_bet_n;
            p1_bet       <= p1_bet_n;
            p2_bet       <= p2_bet_n;
            first_player <= first_n;
        end
    end

endmodule

/* design/score_display.sv */
module score_display
    import poker_pkg::*;
    import display_pkg::*;
#(
    parameter int SCAN_BITS = 16
) (
    input  logic    clk,
    input  logic    reset_d,
    input  round_e  round,
    input  player_t cur_player,
    input  chips_t  pot,
    input  chips_t  p1_balance,
    input  chips_t  p2_balance,
    output seg_t    seg,
    output logic [3:0] an,
    output seg_t    seg2,
    output logic [1:0] an2,
    output seg_t    seg3,
    output logic [1:0] an3
);

    digit_t round_dig;
    digit_t player_dig;
    digit_t pot_tens;
    digit_t pot_units;
    digit_t p1_tens;
    digit_t p1_units;
    digit_t p2_tens;
    digit_t p2_units;
    digit_t main_dig;
    digit_t p1_dig;
    digit_t p2_dig;

    logic [SCAN_BITS-1:0] scan_cnt;
    logic [1:0]           sel;
    logic                 scan_on;   // set at the first scan step.

    function automatic digit_t tens_of(chips_t v);
        return digit_t'(v / 7'd10);
    endfunction

    function automatic digit_t units_of(chips_t v);
        return digit_t'(v % 7'd10);
    endfunction

    always_ff @(posedge clk) begin
        round_dig  <= {2'b00, round};
        player_dig <= {3'b000, cur_player};
        pot_tens   <= tens_of(pot);
        pot_units  <= units_of(pot);
        p1_tens    <= tens_of(p1_balance);
        p1_units   <= units_of(p1_balance);
        p2_tens    <= tens_of(p2_balance);
        p2_units   <= units_of(p2_balance);
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            scan_cnt <= '0;
            sel      <= '0;
            scan_on  <= 1'b0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            if (&scan_cnt) begin
                scan_on <= 1'b1;
                if (scan_on)
                    sel <= sel + 1'b1;
            end
        end
    end

    // an[0] is the rightmost digit.
    always_comb begin
        case (sel)
            2'd0:    main_dig = pot_units;
            2'd1:    main_dig = pot_tens;
            2'd2:    main_dig = player_dig;
            default: main_dig = round_dig;
        endcase
    end

    assign p1_dig = sel[0] ? p1_tens : p1_units;
    assign p2_dig = sel[0] ? p2_tens : p2_units;

    assign an  = scan_on ? ~(4'b0001 << sel) : 4'b1111;
    assign an2 = scan_on ? (sel[0] ? 2'b01 : 2'b10) : 2'b11;
    assign an3 = an2;

    assign seg  = seg_encode(main_dig);
    assign seg2 = ~seg_encode(p1_dig);   // player banks wired inverted.
    assign seg3 = ~seg_encode(p2_dig);

endmodule

/* design/poker_table.sv */
module poker_table
    import poker_pkg::*;
    import display_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 1000000,
    parameter int SCAN_BITS       = 16
) (
    input  logic       clk,
    input  logic       reset_d,
    input  logic       btn_fold,
    input  logic       btn_call,
    input  logic       btn_raise,
    input  logic       sw_cashout,
    input  logic       sw_freeze,
    input  logic       win,
    input  logic       tie,
    output seg_t       seg,
    output logic [3:0] an,
    output seg_t       seg2,
    output logic [1:0] an2,
    output seg_t       seg3,
    output logic [1:0] an3,
    output round_e     round,
    output player_t    cur_player,
    output chips_t     pot,
    output chips_t     p1_balance,
    output chips_t     p2_balance
);

    logic betting_enable;
    logic new_game;

    player_action_if act_if ();

    button_conditioner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) button_conditioner_i (
        .clk        (clk),
        .reset_d    (reset_d),
        .btn_fold   (btn_fold),
        .btn_call   (btn_call),
        .btn_raise  (btn_raise),
        .sw_cashout (sw_cashout),
        .sw_freeze  (sw_freeze),
        .act        (act_if.conditioner)
    );

    game_mode_fsm game_mode_fsm_i (
        .clk            (clk),
        .reset_d        (reset_d),
        .act            (act_if.mode),
        .round          (round),
        .betting_enable (betting_enable),
        .new_game       (new_game)
    );

    betting_engine betting_engine_i (
        .clk            (clk),
        .reset_d        (reset_d),
        .act            (act_if.bet),
        .betting_enable (betting_enable),
        .new_game       (new_game),
        .win            (win),
        .tie            (tie),
        .round          (round),
        .cur_player     (cur_player),
        .pot            (pot),
        .p1_balance     (p1_balance),
        .p2_balance     (p2_balance)
    );

    score_display #(
        .SCAN_BITS (SCAN_BITS)
    ) score_display_i (
        .clk        (clk),
        .reset_d    (reset_d),
        .round      (round),
        .cur_player (cur_player),
        .pot        (pot),
        .p1_balance (p1_balance),
        .p2_balance (p2_balance),
        .seg        (seg),
        .an         (an),
        .seg2       (seg2),
        .an2        (an2),
        .seg3       (seg3),
        .an3        (an3)
    );

endmodule

/* tests/poker_table_tb.sv */
module poker_table_tb
    import poker_pkg::*;
    import display_pkg::*;
();

    localparam int DEBOUNCE   = 4;
    localparam int HOLD       = DEBOUNCE + 8;   // cycles per press and per release.
    localparam int N_DIRECTED = 38;
    localparam int N_RANDOM   = 40;
    localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * 2 * HOLD + 500;

    localparam logic [1:0] ACT_FOLD  = 2'd0;
    localparam logic [1:0] ACT_CALL  = 2'd1;
    localparam logic [1:0] ACT_RAISE = 2'd2;

    typedef struct packed {
        logic [1:0] round;
        player_t    player;
        player_t    first;
        chips_t     pot;
        chips_t     p1;
        chips_t     p2;
        chips_t     cur_bet;
        chips_t     p1_bet;
        chips_t     p2_bet;
    } model_t;

    logic clk;
    logic reset_d;
    logic btn_fold, btn_call, btn_raise;
    logic sw_cashout, sw_freeze;
    logic win, tie;
    seg_t seg, seg2, seg3;
    logic [3:0] an;
    logic [1:0] an2, an3;
    round_e  round;
    player_t cur_player;
    chips_t  pot, p1_balance, p2_balance;

    model_t      model;
    mode_e       tb_mode;
    mode_e       saved_mode;
    logic [15:0] lfsr;
    logic        settled;   // display stable against the model.
    logic [3:0]  an_seen;   // anodes that were active at least once.
    logic [1:0]  an2_seen;
    logic [1:0]  an3_seen;
    int          state_errors;
    int          display_errors;
    int          cycles;
    event        check_ev;

    poker_table #(
        .DEBOUNCE_CYCLES (DEBOUNCE),
        .SCAN_BITS       (2)
    ) poker_table_i (
        .clk (clk), .reset_d (reset_d),
        .btn_fold (btn_fold), .btn_call (btn_call), .btn_raise (btn_raise),
        .sw_cashout (sw_cashout), .sw_freeze (sw_freeze),
        .win (win), .tie (tie),
        .seg (seg), .an (an), .seg2 (seg2), .an2 (an2), .seg3 (seg3), .an3 (an3),
        .round (round), .cur_player (cur_player), .pot (pot),
        .p1_balance (p1_balance), .p2_balance (p2_balance)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    function automatic model_t start_model();
        model_t m;
        m       = '0;
        m.p1    = START_BALANCE;
        m.p2    = START_BALANCE;
        return m;
    endfunction

    // pot and bets clear, the other player opens the next hand.
    function automatic model_t end_hand(model_t m);
        model_t n;
        n         = m;
        n.pot     = '0;
        n.cur_bet = '0;
        n.p1_bet  = '0;
        n.p2_bet  = '0;
        n.round   = 2'd0;
        n.first   = ~m.first;
        n.player  = ~m.first;
        return n;
    endfunction

    function automatic model_t apply_action(model_t m, logic [1:0] act, logic w, logic t);
        model_t n;
        chips_t owed;
        chips_t pot_in;
        n      = m;
        owed   = m.cur_bet - (m.player ? m.p2_bet : m.p1_bet);
        pot_in = m.pot + owed;
        if (act == ACT_FOLD) begin
            if (m.player)
                n.p1 = m.p1 + m.pot;
            else
                n.p2 = m.p2 + m.pot;
            n = end_hand(n);
        end else if (act == ACT_RAISE) begin
            if (m.player) begin
                n.p2     = m.p2 - owed - RAISE_STEP;
                n.p2_bet = m.cur_bet + RAISE_STEP;
            end else begin
                n.p1     = m.p1 - owed - RAISE_STEP;
                n.p1_bet = m.cur_bet + RAISE_STEP;
            end
            n.pot     = m.pot + owed + RAISE_STEP;
            n.cur_bet = m.cur_bet + RAISE_STEP;
            n.player  = ~m.player;
        end else if (m.cur_bet == '0 && m.player == m.first) begin
            n.player = ~m.player;   // opening check.
        end else begin
            if (m.player)
                n.p2 = m.p2 - owed;
            else
                n.p1 = m.p1 - owed;
            n.cur_bet = '0;
            n.p1_bet  = '0;
            n.p2_bet  = '0;
            if (m.round == 2'd3) begin
                if (t) begin
                    n.p1 = n.p1 + pot_in / 2;
                    n.p2 = n.p2 + pot_in / 2;
                end else if (w) begin
                    n.p1 = n.p1 + pot_in;
                end else begin
                    n.p2 = n.p2 + pot_in;
                end
                n = end_hand(n);
            end else begin
                n.pot    = pot_in;
                n.round  = m.round + 2'd1;
                n.player = m.first;
            end
        end
        return n;
    endfunction

    function automatic digit_t main_digit(model_t m, int k);
        case (k)
            0:       return digit_t'(m.pot % 10);
            1:       return digit_t'(m.pot / 10);
            2:       return digit_t'(m.player);
            default: return digit_t'(m.round);
        endcase
    endfunction

    function automatic digit_t balance_digit(chips_t v, int k);
        return (k == 1) ? digit_t'(v / 10) : digit_t'(v % 10);
    endfunction

    task automatic compare_field(input string name, input logic [6:0] got, input logic [6:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            state_errors++;
        end
    endtask

    task automatic compare_seg(input string name, input seg_t got, input seg_t exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            display_errors++;
        end
    endtask

    task automatic check_blank();
        assert (an === 4'hf && an2 === 2'b11 && an3 === 2'b11) else begin
            $display("anodes active during reset: an %h an2 %h an3 %h", an, an2, an3);
            display_errors++;
        end
    endtask

    task automatic check_display();
        assert ($countones(~an) == 1 && $countones(~an2) == 1 && $countones(~an3) == 1)
        else begin
            $display("scan does not select one digit per bank: an %h an2 %h an3 %h",
                     an, an2, an3);
            display_errors++;
        end
        an_seen  = an_seen | ~an;
        an2_seen = an2_seen | ~an2;
        an3_seen = an3_seen | ~an3;
        for (int k = 0; k < 4; k++) begin
            if (an[k] == 1'b0)
                compare_seg("seg", seg, seg_encode(main_digit(model, k)));
        end
        for (int k = 0; k < 2; k++) begin
            if (an2[k] == 1'b0)
                compare_seg("seg2", seg2, ~seg_encode(balance_digit(model.p1, k)));
            if (an3[k] == 1'b0)
                compare_seg("seg3", seg3, ~seg_encode(balance_digit(model.p2, k)));
        end
    endtask

    always @(check_ev) begin
        compare_field("round", 7'(round), 7'(model.round));
        compare_field("cur_player", 7'(cur_player), 7'(model.player));
        compare_field("pot", pot, model.pot);
        compare_field("p1_balance", p1_balance, model.p1);
        compare_field("p2_balance", p2_balance, model.p2);
    end

    always @(negedge clk) begin
        if (reset_d)
            check_blank();
        else if (settled)
            check_display();
    end

    task automatic drive_button(input logic [1:0] act, input logic value);
        case (act)
            ACT_FOLD: btn_fold  = value;
            ACT_CALL: btn_call  = value;
            default:  btn_raise = value;
        endcase
    endtask

    task automatic press(input logic [1:0] act);
        settled = 1'b0;
        drive_button(act, 1'b1);
        repeat (HOLD) @(negedge clk);
        drive_button(act, 1'b0);
        if (tb_mode == mode_playing)
            model = apply_action(model, act, win, tie);
        settled = 1'b1;
        repeat (HOLD) @(negedge clk);
        -> check_ev;
    endtask

    task automatic set_switch(input logic is_freeze, input logic value);
        settled = 1'b0;
        if (is_freeze)
            sw_freeze = value;
        else
            sw_cashout = value;
        repeat (2 * HOLD) @(negedge clk);
        if (is_freeze && value && tb_mode != mode_freeze) begin
            saved_mode = tb_mode;
            tb_mode    = mode_freeze;
        end else if (is_freeze && !value && tb_mode == mode_freeze) begin
            tb_mode = saved_mode;
        end else if (!is_freeze && value && tb_mode == mode_playing && model.round == 2'd0) begin
            tb_mode = mode_cashout;
        end else if (!is_freeze && !value && tb_mode == mode_cashout) begin
            tb_mode = mode_playing;
            model   = start_model();   // new game.
        end
        settled = 1'b1;
        -> check_ev;
    endtask

    task automatic play_hand(input logic w, input logic t);
        win = w;
        tie = t;
        repeat (4) begin
            press(ACT_RAISE);
            press(ACT_CALL);
        end
    endtask

    initial begin
        reset_d = 1'b1;
        btn_fold = 1'b0;
        btn_call = 1'b0;
        btn_raise = 1'b0;
        sw_cashout = 1'b0;
        sw_freeze = 1'b0;
        win = 1'b0;
        tie = 1'b0;
    end

    initial begin : stimulus
        logic [7:0] pick;
        logic [7:0] wbits;
        logic [7:0] tbits;
        logic [1:0] act;
        model = start_model();
        tb_mode = mode_playing;
        saved_mode = mode_playing;
        lfsr = 16'd6;
        settled = 1'b0;
        an_seen = '0;
        an2_seen = '0;
        an3_seen = '0;
        state_errors = 0;
        display_errors = 0;
        repeat (16) @(negedge clk);
        reset_d = 1'b0;
        repeat (HOLD) @(negedge clk);
        settled = 1'b1;
        repeat (HOLD) @(negedge clk);
        -> check_ev;

        play_hand(1'b0, 1'b1);   // showdowns: tie, p1 wins, p2 wins.
        play_hand(1'b1, 1'b0);
        play_hand(1'b0, 1'b0);

        set_switch(1'b1, 1'b1);
        press(ACT_RAISE);        // ignored while frozen.
        set_switch(1'b1, 1'b0);
        press(ACT_RAISE);
        press(ACT_CALL);

        set_switch(1'b0, 1'b1);  // flop, so no cashout.
        press(ACT_RAISE);
        set_switch(1'b0, 1'b0);
        press(ACT_FOLD);
        set_switch(1'b0, 1'b1);
        press(ACT_RAISE);
        set_switch(1'b1, 1'b1);
        set_switch(1'b1, 1'b0);
        set_switch(1'b0, 1'b0);

        for (int i = 0; i < N_RANDOM; i++) begin
            take_bits(3, pick);
            take_bits(1, wbits);
            take_bits(2, tbits);
            win = wbits[0];
            tie = &tbits[1:0];
            // raises only while both stacks cover a raise and a re-raise.
            if (pick[2:0] == 3'd0)
                act = ACT_FOLD;
            else if (pick[2:0] >= 3'd5 && model.p1 >= 7'd15 && model.p2 >= 7'd15)
                act = ACT_RAISE;
            else
                act = ACT_CALL;
            press(act);
        end

        @(negedge clk);
        assert (an_seen == 4'hf && an2_seen == 2'b11 && an3_seen == 2'b11) else begin
            $display("scan never reached every anode: an %h an2 %h an3 %h",
                     an_seen, an2_seen, an3_seen);
            display_errors++;
        end
        $display("errors: %0d state, %0d display", state_errors, display_errors);
        if (state_errors + display_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d state, %0d display", state_errors, display_errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* filelist.f */
design/poker_pkg.sv
design/display_pkg.sv
design/player_action_if.sv
design/button_conditioner.sv
design/game_mode_fsm.sv
design/betting_engine.sv
design/score_display.sv
design/poker_table.sv
tests/poker_table_tb.sv
